// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and storage sizes
`define DATA_WIDTH 32
`define REG_COUNT  32
`define MEM_DEPTH  4096

// Primary opcodes, instruction bits 31:26
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type function codes, instruction bits 5:0
`define FN_SLL   6'h00
`define FN_SLLV  6'h04
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_NOR   6'h27
`define FN_SLT   6'h2a

`endif

// ==== source/corePkg.sv ====
`include "core_config.svh"

package corePkg;

  // R-type view of an instruction word
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeFields;

  // I-type view, same word with a 16-bit immediate in the low half
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeFields;

  // One instruction word, read through either view
  typedef union packed {
    rTypeFields rType;
    iTypeFields iType;
  } instrWord;

  // ALU operation codes
  typedef enum logic [3:0] {
    aluAnd  = 4'd0,
    aluOr   = 4'd1,
    aluAdd  = 4'd2,
    aluSll  = 4'd4,
    aluSllv = 4'd5,
    aluSub  = 4'd6,
    aluSlt  = 4'd7,
    aluXor  = 4'd11,
    aluNor  = 4'd12
  } aluOp;

  // Decode to execute payload
  typedef struct packed {
    aluOp                   op;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [4:0]             shamt;
    logic [4:0]             destReg;
    logic [`DATA_WIDTH-1:0] storeData;
    logic                   isLoad;
    logic                   isStore;
    logic                   writesReg;
  } execPayload;

  // Execute to memory payload
  typedef struct packed {
    // Doubles as the byte address for lw and sw
    logic [`DATA_WIDTH-1:0] result;
    logic [`DATA_WIDTH-1:0] storeData;
    logic [4:0]             destReg;
    logic                   isLoad;
    logic                   isStore;
    logic                   writesReg;
  } memPayload;

endpackage

// ==== source/stageBus.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

// Decode to execute link, with the execute forwarding path running back
interface execBus
  import corePkg::*;
();
  logic                   valid;
  execPayload             payload;
  // Registered ALU result of the execute stage
  logic                   fwdValid;
  logic                   loadPending;
  logic [4:0]             fwdReg;
  logic [`DATA_WIDTH-1:0] fwdData;

  modport decode (output valid, payload, input fwdValid, loadPending, fwdReg, fwdData);
  modport execute (input valid, payload, output fwdValid, loadPending, fwdReg, fwdData);
endinterface

// Execute to memory link
interface memBus
  import corePkg::*;
();
  logic      valid;
  memPayload payload;

  modport source (output valid, payload);
  modport memory (input valid, payload);
endinterface

// Register file write port, also the second forwarding source
interface writeBus
  import corePkg::*;
();
  logic                   wen;
  logic [4:0]             wa;
  logic [`DATA_WIDTH-1:0] wd;

  modport source (output wen, wa, wd);
  modport sink (input wen, wa, wd);
endinterface

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module decodeStage
  import corePkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     instrReq,
  input  instrWord instr,
  output logic     instrAck,
  execBus.decode   ex,
  writeBus.sink    wb
);

  // Register file array
  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  logic [5:0]             opcode;
  logic [4:0]             rs;
  logic [4:0]             rt;
  logic [`DATA_WIDTH-1:0] signImm;
  logic [`DATA_WIDTH-1:0] rsValue;
  logic [`DATA_WIDTH-1:0] rtValue;
  logic                   stall;
  logic                   accept;
  execPayload             decoded;

  // Operand pick: execute result, then writeback bypass, then stored value
  function automatic logic [`DATA_WIDTH-1:0] readOperand(input logic [4:0] ra);
    logic [`DATA_WIDTH-1:0] value;
    if (ra == 5'd0)
      value = '0;
    else if (ex.fwdValid && ex.fwdReg == ra)
      value = ex.fwdData;
    else if (wb.wen && wb.wa == ra)
      // Write-through, value lands in the array on this edge
      value = wb.wd;
    else
      value = regs[ra];
    return value;
  endfunction

  // Fields shared by both views
  assign opcode = instr.rType.opcode;
  assign rs = instr.rType.rs;
  assign rt = instr.rType.rt;
  assign signImm = {{16{instr.iType.imm[15]}}, instr.iType.imm};

  always_comb
  begin
    rsValue = readOperand(rs);
    rtValue = readOperand(rt);
  end

  // Load still in execute, its data not ready until writeback
  assign stall = ex.loadPending && ex.fwdReg != 5'd0 && (ex.fwdReg == rs || ex.fwdReg == rt);
  assign accept = instrReq && !instrAck && !stall;

  always_comb
  begin
    decoded = '0;
    decoded.op = aluAdd;
    decoded.opA = rsValue;
    decoded.opB = rtValue;
    decoded.shamt = instr.rType.shamt;
    decoded.destReg = instr.rType.rd;
    decoded.storeData = rtValue;
    case (opcode)
      `OP_RTYPE:
      begin
        decoded.writesReg = 1'b1;
        case (instr.rType.funct)
          `FN_AND:  decoded.op = aluAnd;
          `FN_OR:   decoded.op = aluOr;
          `FN_ADD:  decoded.op = aluAdd;
          `FN_SUB:  decoded.op = aluSub;
          `FN_SLT:  decoded.op = aluSlt;
          `FN_XOR:  decoded.op = aluXor;
          `FN_NOR:  decoded.op = aluNor;
          `FN_SLL:  decoded.op = aluSll;
          `FN_SLLV: decoded.op = aluSllv;
          // Unsupported funct retires nothing
          default:  decoded.writesReg = 1'b0;
        endcase
      end
      // I-type, add with sign-extended immediate, rt is the target
      `OP_ADDI:
      begin
        decoded.opB = signImm;
        decoded.destReg = rt;
        decoded.writesReg = 1'b1;
      end
      `OP_LW:
      begin
        decoded.opB = signImm;
        decoded.destReg = rt;
        decoded.isLoad = 1'b1;
        decoded.writesReg = 1'b1;
      end
      `OP_SW:
      begin
        decoded.opB = signImm;
        decoded.destReg = rt;
        decoded.isStore = 1'b1;
      end
      default:
      begin
        decoded.writesReg = 1'b0;
      end
    endcase
  end

  // Four-phase acceptance, ack drops once req has dropped
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      instrAck <= 1'b0;
      ex.valid <= 1'b0;
    end
    else
    begin
      ex.valid <= accept;
      if (accept)
        instrAck <= 1'b1;
      else if (!instrReq)
        instrAck <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept)
      ex.payload <= decoded;
  end

  // Register i starts as i, entry 0 never updated
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= `DATA_WIDTH'(i);
    end
    else if (wb.wen && wb.wa != 5'd0)
      regs[wb.wa] <= wb.wd;
  end

  // Ack only answers a pending request
  ackNeedsReq: assert property (@(posedge clock) disable iff (!reset)
    $rose(instrAck) |-> $past(instrReq));

  // Writeback side keeps register 0 off the write port
  noZeroWrite: assert property (@(posedge clock) disable iff (!reset)
    wb.wen |-> wb.wa != 5'd0);

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module executeStage
  import corePkg::*;
(
  input  logic    clock,
  input  logic    reset,
  execBus.execute ex,
  memBus.source   mem
);

  logic [`DATA_WIDTH-1:0] aluResult;
  logic                   memValid;
  memPayload              memEntry;

  // ALU over the decoded operands
  always_comb
  begin
    case (ex.payload.op)
      aluAnd:  aluResult = ex.payload.opA & ex.payload.opB;
      aluOr:   aluResult = ex.payload.opA | ex.payload.opB;
      aluAdd:  aluResult = ex.payload.opA + ex.payload.opB;
      aluSub:  aluResult = ex.payload.opA - ex.payload.opB;
      // Signed compare
      aluSlt:
      begin
        if ($signed(ex.payload.opA) < $signed(ex.payload.opB))
          aluResult = `DATA_WIDTH'(1);
        else
          aluResult = '0;
      end
      aluXor:  aluResult = ex.payload.opA ^ ex.payload.opB;
      aluNor:  aluResult = ~(ex.payload.opA | ex.payload.opB);
      // Shift B by the instruction shamt
      aluSll:  aluResult = ex.payload.opB << ex.payload.shamt;
      // Shift B by the low five bits of A
      aluSllv: aluResult = ex.payload.opB << ex.payload.opA[4:0];
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      memValid <= 1'b0;
    else
      memValid <= ex.valid;
  end

  // Result plus the rest of the payload, held for one cycle
  always_ff @(posedge clock)
  begin
    if (ex.valid)
    begin
      memEntry.result <= aluResult;
      memEntry.storeData <= ex.payload.storeData;
      memEntry.destReg <= ex.payload.destReg;
      memEntry.isLoad <= ex.payload.isLoad;
      memEntry.isStore <= ex.payload.isStore;
      memEntry.writesReg <= ex.payload.writesReg;
    end
  end

  assign mem.valid = memValid;
  assign mem.payload = memEntry;

  // Forward the held result unless it is only a load address
  assign ex.fwdValid = memValid && memEntry.writesReg && !memEntry.isLoad
                       && memEntry.destReg != 5'd0;
  assign ex.loadPending = memValid && memEntry.isLoad;
  assign ex.fwdReg = memEntry.destReg;
  assign ex.fwdData = memEntry.result;

  // Decode only issues known operations
  knownAluOp: assert property (@(posedge clock) disable iff (!reset)
    ex.valid |-> ex.payload.op inside {aluAnd, aluOr, aluAdd, aluSll, aluSllv,
                                       aluSub, aluSlt, aluXor, aluNor});

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module memoryStage
  import corePkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  memBus.memory                  mem,
  writeBus.source                wb,
  output logic                   wbValid,
  output logic [4:0]             wbReg,
  output logic [`DATA_WIDTH-1:0] wbData,
  output logic                   storeValid,
  output logic [`DATA_WIDTH-1:0] storeAddr,
  output logic [`DATA_WIDTH-1:0] storeData
);

  localparam int IndexWidth = $clog2(`MEM_DEPTH);

  logic [`DATA_WIDTH-1:0] dataMem [`MEM_DEPTH];
  logic [IndexWidth-1:0]  wordIndex;
  logic                   memOp;

  // Byte address to word index
  assign wordIndex = mem.payload.result[IndexWidth+1:2];
  assign memOp = mem.valid && (mem.payload.isLoad || mem.payload.isStore);

  // Data memory, cleared on reset
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < `MEM_DEPTH; i++)
        dataMem[i] <= '0;
    end
    else if (mem.valid && mem.payload.isStore)
      dataMem[wordIndex] <= mem.payload.storeData;
  end

  // One-cycle retire and store pulses
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      wbValid <= 1'b0;
      storeValid <= 1'b0;
      wb.wen <= 1'b0;
    end
    else
    begin
      wbValid <= mem.valid && mem.payload.writesReg;
      storeValid <= mem.valid && mem.payload.isStore;
      // Register 0 retires on the port but never reaches the array
      wb.wen <= mem.valid && mem.payload.writesReg && mem.payload.destReg != 5'd0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (mem.valid)
    begin
      wbReg <= mem.payload.destReg;
      // Load reads the word before any store on this edge
      wbData <= mem.payload.isLoad ? dataMem[wordIndex] : mem.payload.result;
      storeAddr <= mem.payload.result;
      storeData <= mem.payload.storeData;
    end
  end

  assign wb.wa = wbReg;
  assign wb.wd = wbData;

  // Decode sets at most one of the two
  loadXorStore: assert property (@(posedge clock) disable iff (!reset)
    mem.valid |-> !(mem.payload.isLoad && mem.payload.isStore));

  // Address stays inside the 4K-word range
  addrInRange: assert property (@(posedge clock) disable iff (!reset)
    memOp |-> mem.payload.result[`DATA_WIDTH-1:IndexWidth+2] == '0);

endmodule

// ==== source/coreTop.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module coreTop
  import corePkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   instrReq,
  input  logic [`DATA_WIDTH-1:0] instr,
  output logic                   instrAck,
  output logic                   wbValid,
  output logic [4:0]             wbReg,
  output logic [`DATA_WIDTH-1:0] wbData,
  output logic                   storeValid,
  output logic [`DATA_WIDTH-1:0] storeAddr,
  output logic [`DATA_WIDTH-1:0] storeData
);

  // Stage links
  execBus  execLink();
  memBus   memLink();
  writeBus writeLink();

  // Raw word seen through the instruction union
  instrWord instrView;

  assign instrView = instrWord'(instr);

  decodeStage decodeUnit (
    .clock    (clock),
    .reset    (reset),
    .instrReq (instrReq),
    .instr    (instrView),
    .instrAck (instrAck),
    .ex       (execLink.decode),
    .wb       (writeLink.sink)
  );

  executeStage executeUnit (
    .clock (clock),
    .reset (reset),
    .ex    (execLink.execute),
    .mem   (memLink.source)
  );

  // Retire point, also feeds the register file write port
  memoryStage memoryUnit (
    .clock      (clock),
    .reset      (reset),
    .mem        (memLink.memory),
    .wb         (writeLink.source),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .storeValid (storeValid),
    .storeAddr  (storeAddr),
    .storeData  (storeData)
  );

endmodule

// ==== tb/coreTb.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module coreTb;

  // Cycles allowed for any single wait
  localparam int WaitLimit = 50;

  logic                   clock;
  logic                   reset;
  logic                   instrReq;
  logic [`DATA_WIDTH-1:0] instr;
  logic                   instrAck;
  logic                   wbValid;
  logic [4:0]             wbReg;
  logic [`DATA_WIDTH-1:0] wbData;
  logic                   storeValid;
  logic [`DATA_WIDTH-1:0] storeAddr;
  logic [`DATA_WIDTH-1:0] storeData;

  // Expected retire results in program order
  logic [7:0]             expKind [$];
  logic [`DATA_WIDTH-1:0] expTarget [$];
  logic [`DATA_WIDTH-1:0] expValue [$];

  // A result is due two edges after each ack rise
  logic ackPrev;
  logic dueNext;
  logic dueNow;

  // Input file reading
  int                     fd;
  int                     code;
  int                     sent;
  int                     cycles;
  logic [7:0]             tag;
  logic [`DATA_WIDTH-1:0] word;
  logic [`DATA_WIDTH-1:0] target;
  logic [`DATA_WIDTH-1:0] value;
  logic [8*256-1:0]       restOfLine;

  coreTop DUT (
    .clock      (clock),
    .reset      (reset),
    .instrReq   (instrReq),
    .instr      (instr),
    .instrAck   (instrAck),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .storeValid (storeValid),
    .storeAddr  (storeAddr),
    .storeData  (storeData)
  );

  // 20 ns period
  always #10 clock = ~clock;

  task automatic stopWithFailure();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic checkValue(input string name, input logic [`DATA_WIDTH-1:0] actual,
                            input logic [`DATA_WIDTH-1:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
      stopWithFailure();
    end
  endtask

  // Poll instrAck just after each edge until it reaches the level
  task automatic waitForAck(input logic level);
    int count;
    count = 0;
    while (instrAck !== level && count < WaitLimit)
    begin
      @(posedge clock);
      #2;
      count++;
    end
    if (instrAck !== level)
    begin
      $display("Error: handshake timed out waiting for instrAck to go %0d", level);
      stopWithFailure();
    end
  endtask

  // One full four-phase transfer
  task automatic sendInstr(input logic [`DATA_WIDTH-1:0] instrWordIn);
    instr = instrWordIn;
    instrReq = 1'b1;
    waitForAck(1'b1);
    instrReq = 1'b0;
    waitForAck(1'b0);
  endtask

  // Compare the retire outputs with the oldest expectation
  task automatic checkRetire();
    logic [7:0]             kind;
    logic [`DATA_WIDTH-1:0] expTgt;
    logic [`DATA_WIDTH-1:0] expVal;
    if (expKind.size() == 0)
    begin
      $display("Error: instrAck rose with no instruction in flight");
      stopWithFailure();
    end
    else
    begin
      kind = expKind.pop_front();
      expTgt = expTarget.pop_front();
      expVal = expValue.pop_front();
      if (kind == "W")
      begin
        checkValue("wbValid", wbValid, 1);
        checkValue("storeValid", storeValid, 0);
        checkValue("wbReg", wbReg, expTgt);
        checkValue("wbData", wbData, expVal);
      end
      else
      begin
        // Stores retire nothing to the register file
        checkValue("storeValid", storeValid, 1);
        checkValue("wbValid", wbValid, 0);
        checkValue("storeAddr", storeAddr, expTgt);
        checkValue("storeData", storeData, expVal);
      end
    end
  endtask

  // Monitor samples mid-cycle where outputs are settled
  always @(negedge clock)
  begin
    if (reset)
    begin
      if (dueNow)
        checkRetire();
      else
      begin
        // No retire pulse outside its slot
        checkValue("wbValid", wbValid, 0);
        checkValue("storeValid", storeValid, 0);
      end
      dueNow = dueNext;
      dueNext = instrAck && !ackPrev;
      ackPrev = instrAck;
    end
  end

  initial
  begin
    clock = 1'b0;
    reset = 1'b0;
    instrReq = 1'b0;
    instr = '0;
    ackPrev = 1'b0;
    dueNext = 1'b0;
    dueNow = 1'b0;
    sent = 0;

    fd = $fopen("tb/program_input.txt", "r");
    if (fd == 0)
    begin
      $display("Error: could not open tb/program_input.txt");
      stopWithFailure();
    end

    // Reset held for two cycles and released just after an edge
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b1;

    // Idle state before the first request
    checkValue("instrAck", instrAck, 0);
    checkValue("wbValid", wbValid, 0);
    checkValue("storeValid", storeValid, 0);

    code = $fscanf(fd, " %c", tag);
    while (code == 1)
    begin
      if (tag == "#")
        // Comment runs to end of line
        code = $fgets(restOfLine, fd);
      else
      begin
        code = $fscanf(fd, " %h %h %h", word, target, value);
        if (code != 3 || (tag != "W" && tag != "S"))
        begin
          $display("Error: malformed line in input file after %0d instructions", sent);
          stopWithFailure();
        end
        // Expectation queued before the request goes out
        expKind.push_back(tag);
        expTarget.push_back(target);
        expValue.push_back(value);
        sendInstr(word);
        sent++;
      end
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);

    // Let the last results retire
    cycles = 0;
    while (expKind.size() != 0 && cycles < WaitLimit)
    begin
      @(posedge clock);
      #2;
      cycles++;
    end

    if (sent == 0 || expKind.size() != 0)
    begin
      $display("Error: %0d of %0d instructions never retired", expKind.size(), sent);
      stopWithFailure();
    end
    else
    begin
      $display("Retired %0d instructions", sent);
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== list.f ====
+incdir+source
source/corePkg.sv
source/stageBus.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/coreTop.sv
tb/coreTb.sv

// ==== tb/program_input.txt ====
# kind instr target value, all hex; W: target is wbReg, value is wbData
# S: target is storeAddr, value is storeData; register i starts as i
# opcodes R-type 00, addi 08, lw 23, sw 2b
W 00ec5024 0a 00000004  # and r10, r7, r12
W 00aa5825 0b 00000005  # or r11, r5, r10 (r10 from execute)
W 01696020 0c 0000000e  # add r12, r11, r9
W 006c6822 0d fffffff5  # sub r13, r3, r12 gives -11
W 01a2702a 0e 00000001  # slt r14, r13, r2 negative operand
W 004d782a 0f 00000000  # slt r15, r2, r13
W 00c98026 10 0000000f  # xor r16, r6, r9
W 02038827 11 fffffff0  # nor r17, r16, r3
W 00039100 12 00000030  # sll r18, r3, 4
W 00929804 13 00000300  # sllv r19, r18, r4
W 2274fff8 14 000002f8  # addi r20, r19, -8
W 2015ff9c 15 ffffff9c  # addi r21, r0, -100
S ad140010 00000018 000002f8  # sw r20, 16(r8)
W 8c160018 16 000002f8  # lw r22, 24(r0)
W 02d5b820 17 00000294  # add r23, r22, r21 load-use stall
S ac970028 0000002c 00000294  # sw r23, 40(r4) data from execute
W 8c18002c 18 00000294  # lw r24, 44(r0)
W 8c190018 19 000002f8  # lw r25, 24(r0) no stall
W 0338d022 1a 00000064  # sub r26, r25, r24 stall
W 00a60020 00 0000000b  # add r0, r5, r6 retires, r0 unchanged
W 0007d825 1b 00000007  # or r27, r0, r7
W 201c0005 1c 00000005  # addi r28, r0, 5
W 8c1d002c 1d 00000294  # lw r29, 44(r0)
S ac1d0030 00000030 00000294  # sw r29, 48(r0) stall on store data
W 8c1e0030 1e 00000294  # lw r30, 48(r0)
W 03c0f827 1f fffffd6b  # nor r31, r30, r0 stall
W 03fc102a 02 00000001  # slt r2, r31, r28
W 00021fc0 03 80000000  # sll r3, r2, 31
W 007f2026 04 7ffffd6b  # xor r4, r3, r31
W 00042822 05 80000295  # sub r5, r0, r4
W 00a4302a 06 00000001  # slt r6, r5, r4
W 00953824 07 7ffffd08  # and r7, r4, r21
